/* logic/chip8_pkg.sv */
// Shared widths, host address map, enums and bus structs, imported by every CHIP-8 core file
package chip8_pkg;

    typedef logic [11:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] opcode_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [16:0] host_addr_t;
    typedef logic [31:0] host_data_t;

    localparam addr_t PC_RESET = 12'h200;

    // Host map, memory lives above bit 16
    localparam int         HOST_MEM_BIT = 16;
    localparam host_addr_t HOST_V_LAST  = 17'h0F;
    localparam host_addr_t HOST_I       = 17'h10;
    localparam host_addr_t HOST_DELAY   = 17'h12;
    localparam host_addr_t HOST_PC      = 17'h14;
    localparam host_addr_t HOST_STATE   = 17'h16;

    typedef enum logic [1:0] {
        RUNNING = 2'd0,
        PAUSED  = 2'd3
    } run_state_t;

    typedef enum logic [2:0] {
        SEL_V,
        SEL_I,
        SEL_DELAY,
        SEL_PC,
        SEL_NONE
    } reg_sel_t;

    typedef struct packed {
        logic       sel;
        logic       write;
        host_addr_t address;
        host_data_t wdata;
    } host_req_t;

    typedef struct packed {
        addr_t   pc;
        opcode_t opcode;
    } fetch_item_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // Host side register request into execute
    typedef struct packed {
        reg_sel_t   sel;
        logic       write;
        reg_idx_t   index;
        host_data_t data;
    } reg_access_t;

endpackage

/* logic/chip8_host_port.sv */
// Host bus decoder with run state register, port A arbitration and two-cycle read return
`timescale 1ns/1ps

module chip8_host_port (
    input  logic                   clk,
    input  logic                   cpu_fbreset,
    input  chip8_pkg::host_req_t   host_req,
    output chip8_pkg::run_state_t  run_state,
    output chip8_pkg::addr_t       mem_a_addr,
    output logic                   mem_a_we,
    output chip8_pkg::byte_t       mem_a_wdata,
    input  chip8_pkg::byte_t       mem_a_rdata,
    input  chip8_pkg::addr_t       fetch_a_addr,
    output chip8_pkg::reg_access_t reg_req,
    input  chip8_pkg::host_data_t  reg_rdata,
    output logic                   timer_we,
    output chip8_pkg::byte_t       timer_wdata,
    input  chip8_pkg::byte_t       timer_value,
    output chip8_pkg::host_data_t  host_rdata,
    output logic                   host_rvalid
);
    import chip8_pkg::*;

    logic     paused;
    logic     is_mem;
    logic     is_state;
    logic     wr_ok;
    reg_sel_t sel;

    logic     rd_pending_q;
    logic     rd_mem_q;
    logic     rd_state_q;
    reg_sel_t rd_sel_q;

    assign paused   = (run_state == PAUSED);
    assign is_mem   = host_req.address[HOST_MEM_BIT];
    assign is_state = !is_mem && (host_req.address == HOST_STATE);
    // State writes are not gated by this
    assign wr_ok    = host_req.sel && host_req.write && paused;

    always_comb begin
        sel = SEL_NONE;
        if (host_req.sel && !is_mem) begin
            case (host_req.address) inside
                [17'h00:HOST_V_LAST]: sel = SEL_V;
                HOST_I:               sel = SEL_I;
                HOST_DELAY:           sel = SEL_DELAY;
                HOST_PC:              sel = SEL_PC;
                default:              sel = SEL_NONE;
            endcase
        end
    end

    assign reg_req = '{sel: sel, write: wr_ok, index: host_req.address[3:0],
                       data: host_req.wdata};

    assign timer_we    = wr_ok && (sel == SEL_DELAY);
    assign timer_wdata = host_req.wdata[7:0];

    // Fetch owns port A whenever the core runs
    assign mem_a_addr  = paused ? host_req.address[11:0] : fetch_a_addr;
    assign mem_a_we    = wr_ok && is_mem;
    assign mem_a_wdata = host_req.wdata[7:0];

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            run_state <= PAUSED;
        end else if (host_req.sel && host_req.write && is_state) begin
            // Any nonzero code parks the core
            run_state <= (host_req.wdata[1:0] == 2'd0) ? RUNNING : PAUSED;
        end
    end

    // First read stage remembers the source
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            rd_pending_q <= 1'b0;
        end else begin
            rd_pending_q <= host_req.sel;
        end
    end

    always_ff @(posedge clk) begin
        rd_mem_q   <= is_mem;
        rd_state_q <= is_state;
        rd_sel_q   <= sel;
    end

    // Second stage returns the data
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= rd_pending_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_mem_q) begin
            host_rdata <= {24'h0, mem_a_rdata};
        end else if (rd_state_q) begin
            host_rdata <= {30'h0, run_state};
        end else begin
            case (rd_sel_q)
                SEL_V, SEL_I, SEL_PC: host_rdata <= reg_rdata;
                SEL_DELAY:            host_rdata <= {24'h0, timer_value};
                default:              host_rdata <= '0;
            endcase
        end
    end

    // Each request cycle is answered two cycles later
    assert property (@(posedge clk) disable iff (cpu_fbreset)
        host_req.sel |-> ##2 host_rvalid);

endmodule

/* logic/chip8_program_mem.sv */
// Dual-port 4 KiB program RAM, port A read/write for host and fetch, port B read-only for fetch
`timescale 1ns/1ps

module chip8_program_mem (
    input  logic             clk,
    input  chip8_pkg::addr_t a_addr,
    input  logic             a_we,
    input  chip8_pkg::byte_t a_wdata,
    output chip8_pkg::byte_t a_rdata,
    input  chip8_pkg::addr_t b_addr,
    output chip8_pkg::byte_t b_rdata
);
    import chip8_pkg::*;

    byte_t mem [4096];

    // Read returns the old byte on a same-cycle write
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_wdata;
        end
        a_rdata <= mem[a_addr];
    end

    always_ff @(posedge clk) begin
        b_rdata <= mem[b_addr];
    end

endmodule

/* logic/chip8_fetch.sv */
// Fetch stage, issues two-byte opcode reads from its own pc while credits remain
`timescale 1ns/1ps

module chip8_fetch #(
    parameter int FETCH_CREDITS = 4
) (
    input  logic                   clk,
    input  logic                   cpu_fbreset,
    input  chip8_pkg::run_state_t  run_state,
    input  chip8_pkg::redirect_t   redirect,
    input  logic                   credit_return,
    output chip8_pkg::addr_t       mem_hi_addr,
    output chip8_pkg::addr_t       mem_lo_addr,
    input  chip8_pkg::byte_t       mem_hi_rdata,
    input  chip8_pkg::byte_t       mem_lo_rdata,
    output chip8_pkg::fetch_item_t item,
    output logic                   item_valid
);
    import chip8_pkg::*;

    localparam int CW = $clog2(FETCH_CREDITS + 1);

    addr_t         fetch_pc;
    addr_t         issue_pc;
    addr_t         issued_pc_q;
    logic [CW-1:0] credits;
    logic          issue;

    // A redirect is issued from in the same cycle it arrives
    assign issue_pc = redirect.valid ? redirect.target : fetch_pc;
    assign issue    = (run_state == RUNNING) && (credits != '0);

    assign mem_hi_addr = issue_pc;
    assign mem_lo_addr = issue_pc + 12'd1;

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            fetch_pc   <= PC_RESET;
            credits    <= CW'(FETCH_CREDITS);
            item_valid <= 1'b0;
        end else begin
            fetch_pc   <= issue ? issue_pc + 12'd2 : issue_pc;
            credits    <= credits + CW'(credit_return) - CW'(issue);
            item_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            issued_pc_q <= issue_pc;
        end
    end

    // Bytes arrive one cycle after issue, tag them with the issued pc
    assign item = '{pc: issued_pc_q, opcode: {mem_hi_rdata, mem_lo_rdata}};

    // Execute hands back no more credits than were spent
    assert property (@(posedge clk) disable iff (cpu_fbreset)
        credits <= CW'(FETCH_CREDITS));

endmodule

/* logic/chip8_execute.sv */
// Execute stage with instruction queue, decode, V/I registers and committed pc with redirect
`timescale 1ns/1ps

module chip8_execute #(
    parameter int FETCH_CREDITS = 4
) (
    input  logic                   clk,
    input  logic                   cpu_fbreset,
    input  chip8_pkg::fetch_item_t item,
    input  logic                   item_valid,
    output logic                   credit_return,
    output chip8_pkg::redirect_t   redirect,
    input  chip8_pkg::reg_access_t reg_req,
    output chip8_pkg::host_data_t  reg_rdata,
    output logic                   timer_we,
    output chip8_pkg::byte_t       timer_wdata
);
    import chip8_pkg::*;

    localparam int PW = $clog2(FETCH_CREDITS);
    localparam int CW = $clog2(FETCH_CREDITS + 1);

    fetch_item_t   queue [FETCH_CREDITS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;
    fetch_item_t   head;

    byte_t         v_regs [16];
    logic [15:0]   i_reg;
    addr_t         pc_q;

    logic          retire;
    reg_idx_t      x;
    byte_t         nn;
    logic          v_we;
    byte_t         v_wdata;
    logic          i_we;
    logic          jump;
    addr_t         pc_next;
    logic          host_pc_we;

    // One item leaves the queue every cycle it is non-empty
    assign pop           = (count != '0);
    assign credit_return = pop;
    assign head          = queue[rd_ptr];
    // Only the item at the committed pc is on the right path
    assign retire        = pop && (head.pc == pc_q);
    assign x             = head.opcode[11:8];
    assign nn            = head.opcode[7:0];
    assign host_pc_we    = reg_req.write && (reg_req.sel == SEL_PC);

    always_comb begin
        v_we        = 1'b0;
        v_wdata     = nn;
        i_we        = 1'b0;
        jump        = 1'b0;
        timer_we    = 1'b0;
        timer_wdata = v_regs[x];
        pc_next     = pc_q + 12'd2;
        if (retire) begin
            case (head.opcode[15:12])
                4'h1: begin
                    pc_next = head.opcode[11:0];
                    jump    = 1'b1;
                end
                4'h3: begin
                    if (v_regs[x] == nn) begin
                        pc_next = pc_q + 12'd4;
                        jump    = 1'b1;
                    end
                end
                4'h6: v_we = 1'b1;
                4'h7: begin
                    v_we    = 1'b1;
                    v_wdata = v_regs[x] + nn;
                end
                4'hA: i_we = 1'b1;
                4'hF: timer_we = (nn == 8'h15);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (item_valid) begin
                wr_ptr <= (wr_ptr == PW'(FETCH_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FETCH_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(item_valid) - CW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (item_valid) begin
            queue[wr_ptr] <= item;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            for (int r = 0; r < 16; r++) begin
                v_regs[r] <= '0;
            end
            i_reg    <= '0;
            pc_q     <= PC_RESET;
            redirect <= '0;
        end else begin
            redirect.valid  <= jump || host_pc_we;
            redirect.target <= host_pc_we ? reg_req.data[11:0] : pc_next;
            if (retire) begin
                pc_q <= pc_next;
            end
            if (v_we) begin
                v_regs[x] <= v_wdata;
            end
            if (i_we) begin
                i_reg <= {4'h0, head.opcode[11:0]};
            end
            // Host writes land last and win over a draining instruction
            if (reg_req.write) begin
                case (reg_req.sel)
                    SEL_V:   v_regs[reg_req.index] <= reg_req.data[7:0];
                    SEL_I:   i_reg <= reg_req.data[15:0];
                    SEL_PC:  pc_q <= reg_req.data[11:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        case (reg_req.sel)
            SEL_V:   reg_rdata <= {24'h0, v_regs[reg_req.index]};
            SEL_I:   reg_rdata <= {16'h0, i_reg};
            SEL_PC:  reg_rdata <= {20'h0, pc_q};
            default: reg_rdata <= '0;
        endcase
    end

    // Fetch credits keep the queue from overflowing
    assert property (@(posedge clk) disable iff (cpu_fbreset)
        item_valid |-> (count < CW'(FETCH_CREDITS)));

endmodule

/* logic/chip8_delay_timer.sv */
// Delay timer, a free-running tick divider and a byte counter that decrements to zero
`timescale 1ns/1ps

module chip8_delay_timer #(
    parameter int TICK_DIV = 833333
) (
    input  logic             clk,
    input  logic             cpu_fbreset,
    input  logic             we,
    input  chip8_pkg::byte_t wdata,
    output chip8_pkg::byte_t value
);
    localparam int DW = $clog2(TICK_DIV);

    logic [DW-1:0] div_q;
    logic          tick;

    assign tick = (div_q == DW'(TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            div_q <= '0;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;
        end
    end

    // A load beats a tick in the same cycle
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            value <= '0;
        end else if (we) begin
            value <= wdata;
        end else if (tick && (value != '0)) begin
            value <= value - 8'd1;
        end
    end

endmodule

/* logic/chip8_top.sv */
// Core top level, connects host port, program memory, fetch, execute and delay timer
`timescale 1ns/1ps

module chip8_top #(
    parameter int FETCH_CREDITS = 4,
    parameter int TICK_DIV      = 833333
) (
    input  logic                  clk,
    input  logic                  cpu_fbreset,
    input  chip8_pkg::host_req_t  host_req,
    output chip8_pkg::host_data_t host_rdata,
    output logic                  host_rvalid
);
    import chip8_pkg::*;

    run_state_t  run_state;
    addr_t       mem_a_addr;
    logic        mem_a_we;
    byte_t       mem_a_wdata;
    byte_t       mem_a_rdata;
    addr_t       fetch_a_addr;
    addr_t       mem_lo_addr;
    byte_t       mem_lo_rdata;
    reg_access_t reg_req;
    host_data_t  reg_rdata;
    redirect_t   redirect;
    logic        credit_return;
    fetch_item_t item;
    logic        item_valid;
    logic        host_timer_we;
    byte_t       host_timer_wdata;
    logic        exec_timer_we;
    byte_t       exec_timer_wdata;
    logic        timer_we;
    byte_t       timer_wdata;
    byte_t       timer_value;

    // Host loads only while paused, so the two sources never collide
    assign timer_we    = host_timer_we || exec_timer_we;
    assign timer_wdata = host_timer_we ? host_timer_wdata : exec_timer_wdata;

    chip8_host_port i_host_port (
        .clk          (clk),
        .cpu_fbreset  (cpu_fbreset),
        .host_req     (host_req),
        .run_state    (run_state),
        .mem_a_addr   (mem_a_addr),
        .mem_a_we     (mem_a_we),
        .mem_a_wdata  (mem_a_wdata),
        .mem_a_rdata  (mem_a_rdata),
        .fetch_a_addr (fetch_a_addr),
        .reg_req      (reg_req),
        .reg_rdata    (reg_rdata),
        .timer_we     (host_timer_we),
        .timer_wdata  (host_timer_wdata),
        .timer_value  (timer_value),
        .host_rdata   (host_rdata),
        .host_rvalid  (host_rvalid)
    );

    chip8_program_mem i_program_mem (
        .clk     (clk),
        .a_addr  (mem_a_addr),
        .a_we    (mem_a_we),
        .a_wdata (mem_a_wdata),
        .a_rdata (mem_a_rdata),
        .b_addr  (mem_lo_addr),
        .b_rdata (mem_lo_rdata)
    );

    chip8_fetch #(
        .FETCH_CREDITS (FETCH_CREDITS)
    ) i_fetch (
        .clk           (clk),
        .cpu_fbreset   (cpu_fbreset),
        .run_state     (run_state),
        .redirect      (redirect),
        .credit_return (credit_return),
        .mem_hi_addr   (fetch_a_addr),
        .mem_lo_addr   (mem_lo_addr),
        .mem_hi_rdata  (mem_a_rdata),
        .mem_lo_rdata  (mem_lo_rdata),
        .item          (item),
        .item_valid    (item_valid)
    );

    chip8_execute #(
        .FETCH_CREDITS (FETCH_CREDITS)
    ) i_execute (
        .clk           (clk),
        .cpu_fbreset   (cpu_fbreset),
        .item          (item),
        .item_valid    (item_valid),
        .credit_return (credit_return),
        .redirect      (redirect),
        .reg_req       (reg_req),
        .reg_rdata     (reg_rdata),
        .timer_we      (exec_timer_we),
        .timer_wdata   (exec_timer_wdata)
    );

    chip8_delay_timer #(
        .TICK_DIV (TICK_DIV)
    ) i_delay_timer (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .we          (timer_we),
        .wdata       (timer_wdata),
        .value       (timer_value)
    );

endmodule

/* test/chip8_tb.sv */
// Directed testbench that runs small programs on the CHIP-8 core over the host bus and checks results
`timescale 1ns/1ps

module chip8_tb;
    import chip8_pkg::*;

    localparam int FETCH_CREDITS = 4;
    localparam int TICK_DIV      = 16;
    localparam int RVALID_LIMIT  = 10;
    localparam int POLL_LIMIT    = 100;

    logic       clk;
    logic       cpu_fbreset;
    host_req_t  host_req;
    host_data_t host_rdata;
    logic       host_rvalid;

    int          error_count;
    int          check_count;
    int          test_count;
    int          failed_tests;
    logic [31:0] lcg_state;
    opcode_t     program_q[$];

    chip8_top #(
        .FETCH_CREDITS (FETCH_CREDITS),
        .TICK_DIV      (TICK_DIV)
    ) i_chip8_top (
        .clk         (clk),
        .cpu_fbreset (cpu_fbreset),
        .host_req    (host_req),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic host_addr_t mem_addr(input addr_t a);
        return {1'b1, 4'h0, a};
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input host_data_t got, input host_data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // One request cycle, then wait for the response pulse
    task automatic host_access(input logic write, input host_addr_t address,
                               input host_data_t wdata, output host_data_t rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        host_req = '{sel: 1'b1, write: write, address: address, wdata: wdata};
        @(negedge clk);
        host_req.sel   = 1'b0;
        host_req.write = 1'b0;
        while (!host_rvalid && waited < RVALID_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (host_rvalid) begin
            rdata = host_rdata;
        end else begin
            error_count++;
            rdata = '0;
            $display("No host response for address 0x%h within %0d cycles", address,
                     RVALID_LIMIT);
        end
    endtask

    task automatic host_write(input host_addr_t address, input host_data_t wdata);
        host_data_t unused;
        host_access(1'b1, address, wdata, unused);
    endtask

    task automatic host_read(input host_addr_t address, output host_data_t rdata);
        host_access(1'b0, address, '0, rdata);
    endtask

    // Program bytes go in big-endian, then pc points at the start
    task automatic load_program(input addr_t base);
        addr_t a;
        foreach (program_q[k]) begin
            a = base + addr_t'(2 * k);
            host_write(mem_addr(a), {24'h0, program_q[k][15:8]});
            host_write(mem_addr(a + 12'd1), {24'h0, program_q[k][7:0]});
        end
        host_write(HOST_PC, {20'h0, base});
    endtask

    task automatic pause_core();
        host_write(HOST_STATE, 32'd3);
        // Queue drains within FETCH_CREDITS + 2 cycles
        repeat (FETCH_CREDITS + 2) @(negedge clk);
    endtask

    task automatic run_then_pause(input int cycles);
        host_write(HOST_STATE, 32'd0);
        repeat (cycles) @(negedge clk);
        pause_core();
    endtask

    task automatic finish_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            failed_tests++;
            $display("Test %s: %0d errors", name, error_count - start_errors);
        end
    endtask

    task automatic test_reset_values();
        host_data_t d;
        int         start;
        start = error_count;
        host_read(HOST_PC, d);
        check_addr("pc", d[11:0], 12'h200);
        host_read(HOST_STATE, d);
        check_word("state", d, 32'd3);
        host_read(17'h00, d);
        check_byte("v0", d[7:0], 8'h00);
        host_read(17'h0F, d);
        check_byte("vf", d[7:0], 8'h00);
        host_read(HOST_I, d);
        check_word("i", d, 32'h0);
        finish_test("reset_values", start);
    endtask

    task automatic test_paused_access();
        host_data_t d;
        host_data_t w;
        byte_t      mem_data [8];
        byte_t      v_data [6];
        int         start;
        start = error_count;
        for (int k = 0; k < 8; k++) begin
            mem_data[k] = byte_t'(next_random() >> 16);
            host_write(mem_addr(12'h300 + addr_t'(37 * k)), {24'h0, mem_data[k]});
        end
        for (int k = 0; k < 8; k++) begin
            host_read(mem_addr(12'h300 + addr_t'(37 * k)), d);
            check_byte("mem", d[7:0], mem_data[k]);
        end
        for (int r = 0; r < 6; r++) begin
            v_data[r] = byte_t'(next_random() >> 8);
            host_write(host_addr_t'(r + 1), {24'h0, v_data[r]});
        end
        for (int r = 0; r < 6; r++) begin
            host_read(host_addr_t'(r + 1), d);
            check_byte("v", d[7:0], v_data[r]);
        end
        w = next_random();
        host_write(HOST_I, w);
        host_read(HOST_I, d);
        check_word("i", {16'h0, d[15:0]}, {16'h0, w[15:0]});
        w = next_random();
        host_write(HOST_PC, {20'h0, w[11:0]});
        host_read(HOST_PC, d);
        check_addr("pc", d[11:0], w[11:0]);
        finish_test("paused_access", start);
    endtask

    task automatic test_straight_line();
        host_data_t d;
        int         start;
        start = error_count;
        // VA = 0x12 + 0x05, I = 0x345, then spin at 0x206
        program_q = '{16'h6A12, 16'h7A05, 16'hA345, 16'h1206};
        load_program(12'h200);
        run_then_pause(40);
        host_read(17'h0A, d);
        check_byte("va", d[7:0], 8'h17);
        host_read(HOST_I, d);
        check_word("i", d, 32'h345);
        host_read(HOST_PC, d);
        check_addr("pc", d[11:0], 12'h206);
        finish_test("straight_line", start);
    endtask

    task automatic test_skip_jump();
        host_data_t d;
        int         start;
        start = error_count;
        program_q = '{16'h6B00, 16'h6C00, 16'h6D01, 16'h6177,
                      16'h3177, 16'h6BFF,   // taken skip
                      16'h3178, 16'h6C42,   // not taken
                      16'h1216, 16'h6DEE, 16'h6DEE,
                      16'h7D01, 16'h1218};
        load_program(12'h200);
        run_then_pause(60);
        host_read(17'h01, d);
        check_byte("v1", d[7:0], 8'h77);
        host_read(17'h0B, d);
        check_byte("vb", d[7:0], 8'h00);
        host_read(17'h0C, d);
        check_byte("vc", d[7:0], 8'h42);
        host_read(17'h0D, d);
        check_byte("vd", d[7:0], 8'h02);
        host_read(HOST_PC, d);
        check_addr("pc", d[11:0], 12'h218);
        finish_test("skip_jump", start);
    endtask

    task automatic test_timer_and_run_writes();
        host_data_t d;
        int         polls;
        int         start;
        start = error_count;
        program_q = '{16'h6505, 16'hF515, 16'h1204};
        load_program(12'h200);
        run_then_pause(12);
        host_read(HOST_DELAY, d);
        check_count++;
        if (d[7:0] < 8'd1 || d[7:0] > 8'd5) begin
            error_count++;
            $display("CHECK FAILED delay: got 0x%h, expected 0x01 to 0x05", d[7:0]);
        end
        polls = 0;
        while (d[7:0] != 8'h00 && polls < POLL_LIMIT) begin
            host_read(HOST_DELAY, d);
            polls++;
        end
        if (d[7:0] != 8'h00) begin
            error_count++;
            $display("Delay timer did not reach zero within %0d reads", POLL_LIMIT);
        end
        host_write(17'h01, 32'h5A);
        host_write(HOST_STATE, 32'd0);
        host_write(17'h01, 32'hA5);
        pause_core();
        host_read(17'h01, d);
        check_byte("v1", d[7:0], 8'h5A);
        finish_test("timer_and_run_writes", start);
    endtask

    initial begin
        host_req     = '0;
        cpu_fbreset  = 1'b1;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        lcg_state    = 32'd29647;
        repeat (5) @(negedge clk);
        cpu_fbreset = 1'b0;
        test_reset_values();
        test_paused_access();
        test_straight_line();
        test_skip_jump();
        test_timer_and_run_writes();
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/chip8_pkg.sv
logic/chip8_host_port.sv
logic/chip8_program_mem.sv
logic/chip8_fetch.sv
logic/chip8_execute.sv
logic/chip8_delay_timer.sv
logic/chip8_top.sv
test/chip8_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module chip8_tb -o chip8_sim

./obj_dir/chip8_sim > sim.log
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
